//--- vlog.f
+incdir+tests
rtl/arcade_pkg.sv
rtl/rom_loader.sv
rtl/key_decoder.sv
rtl/control_mapper.sv
rtl/audio_dac.sv
rtl/video_out.sv
rtl/arcade_glue.sv
tests/arcade_glue_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= arcade_glue_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard tests/*.svh)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_checks.svh
/* Clock stepping, value checks and key events for arcade_glue_tb.
   Included inside the testbench module body. */
`ifndef tb_checks_svh
`define tb_checks_svh

// next rising edge, then on to the drive point
task automatic next_cycle();
	@(posedge clk_sys);
	#(drive_delay_ns);
endtask

task automatic stop_with_error(string what);
	$display("%s", what);
	$display("ERRORS FOUND");
	$fatal(1, "stopped at the first failed check");
endtask

task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
	assert (got === expected)
	else stop_with_error($sformatf("mismatch at time %0t: %s is %0h, expected %0h",
		$time, name, got, expected));
endtask

task automatic wait_game_reset_low(int max_cycles);
	int waited;
	waited = 0;
	while (game_reset !== 1'b0 && waited < max_cycles) begin
		next_cycle();
		waited++;
	end
	assert (game_reset === 1'b0)
	else stop_with_error("timeout waiting for game_reset to fall after the download");
endtask

// single-cycle strobe for one make or break event
task automatic send_key(logic [7:0] code, logic pressed);
	{key_strobe, key_pressed, key_code} = {1'b1, pressed, code};
	next_cycle();
	key_strobe = 1'b0;
endtask

function automatic logic [8:0] key_levels();
	return {up, down, left, right, fire, bomb, coin, one_player, two_players};
endfunction

`endif

//--- tests/arcade_glue_tb.sv
/* Testbench for arcade_glue covering download, game reset, keys, controls,
   video and audio. Helpers come from tb_checks.svh. */
`timescale 1ns/1ps

module arcade_glue_tb;

	localparam int drive_delay_ns = 5;

	logic clk_sys, arst_n, ioctl_download, ioctl_wr, key_strobe, key_pressed, hs, vs, blankn;
	logic game_reset, up, down, left, right, fire, bomb, coin, one_player, two_players;
	logic vga_hs, vga_vs, audio_l, audio_r;
	logic [24:0] ioctl_addr;
	logic [14:0] rom_addr;
	logic [7:0] ioctl_dout, rom_data, key_code, joystick_0, joystick_1, audio;
	logic [31:0] status;
	logic [1:0] buttons, r;
	logic [2:0] g, b;
	logic [5:0] vga_r, vga_g, vga_b;
	logic [7:0] rom_image [64];
	logic [7:0] key_table [9] = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h29, 8'h11,	// moves, fire, bomb
		8'h76, 8'h05, 8'h06};	// coin, 1p, 2p

	arcade_glue u_arcade_glue (.*);

	`include "tb_checks.svh"

	// expected {up, down, left, right, fire, bomb} for one joystick bit
	function automatic logic [5:0] joystick_controls(int bit_idx, logic rotate);
		case (bit_idx)
			0: return rotate ? 6'b000100 : 6'b010000;
			1: return rotate ? 6'b001000 : 6'b100000;
			2: return rotate ? 6'b010000 : 6'b001000;
			3: return rotate ? 6'b100000 : 6'b000100;
			4: return 6'b000010;
			default: return 6'b000001;
		endcase
	endfunction

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		int ones;
		void'($urandom(32'h966ed6fe));
		{arst_n, ioctl_download, ioctl_wr, key_strobe, key_pressed, hs, vs, blankn} = '0;
		{ioctl_addr, rom_addr, ioctl_dout, key_code, joystick_0, joystick_1, audio} = '0;
		{status, buttons, r, g, b} = '0;
		repeat (5) @(posedge clk_sys);
		#(drive_delay_ns) arst_n = 1'b1;

		ioctl_download = 1'b1;
		for (int i = 0; i < 64; i++) begin
			rom_image[i] = 8'($urandom);
			{ioctl_wr, ioctl_addr, ioctl_dout} = {1'b1, 25'(i), rom_image[i]};
			next_cycle();
			check_value("game_reset", 32'(game_reset), 32'd1);	// held while loading
		end
		{ioctl_wr, ioctl_download} = '0;
		wait_game_reset_low(10);
		for (int i = 0; i < 64; i++) begin
			rom_addr = 15'(i);
			next_cycle();
			check_value("rom_data", 32'(rom_data), 32'(rom_image[i]));
		end

		for (int src = 0; src < 3; src++) begin
			{status[0], status[6], buttons[1]} = 3'b100 >> src;	// one source at a time
			next_cycle();
			check_value("game_reset", 32'(game_reset), 32'd1);
			{status[0], status[6], buttons[1]} = '0;
			next_cycle();
			check_value("game_reset", 32'(game_reset), 32'd0);
		end

		status[2] = 1'b1;
		for (int k = 0; k < 9; k++) begin
			send_key(key_table[k], 1'b1);
			check_value("key levels", 32'(key_levels()), 32'((9'h100 >> k) & 9'h7));
			next_cycle();	// mapped outputs lag one more cycle
			check_value("key levels", 32'(key_levels()), 32'(9'h100 >> k));
			send_key(key_table[k], 1'b0);
			next_cycle();
			check_value("key levels", 32'(key_levels()), 32'd0);
		end
		send_key(8'h29, 1'b1);	// hold fire
		send_key(8'h1C, 1'b1);	// letter a is not a game key
		send_key(8'hE0, 1'b0);
		next_cycle();
		check_value("key levels", 32'(key_levels()), 32'h010);
		send_key(8'h29, 1'b0);

		for (int rot = 1; rot >= 0; rot--) begin
			status[2] = rot[0];
			for (int n = 0; n < 12; n++) begin
				joystick_0 = n < 6 ? 8'(1 << n) : 8'h00;
				joystick_1 = n < 6 ? 8'h00 : 8'(1 << (n - 6));
				next_cycle();
				check_value("controls", 32'(key_levels() >> 3),
					32'(joystick_controls(n % 6, rot[0])));
			end
		end
		{joystick_0, joystick_1} = '0;

		for (int n = 0; n < 40; n++) begin
			{r, g, b, hs, vs} = 10'($urandom);
			blankn = n[0];
			next_cycle();
			check_value("vga_r", 32'(vga_r), blankn ? 32'({3{r}}) : 32'd0);
			check_value("vga_g", 32'(vga_g), blankn ? 32'({2{g}}) : 32'd0);
			check_value("vga_b", 32'(vga_b), blankn ? 32'({2{b}}) : 32'd0);
			check_value("vga_hs, vga_vs", 32'({vga_hs, vga_vs}), 32'({hs, vs}));
		end

		audio = 8'h40;	// dac sees 16'h4040
		ones = 0;
		for (int n = 0; n < 65536; n++) begin
			next_cycle();
			check_value("audio_r", 32'(audio_r), 32'(audio_l));
			if (audio_l) ones++;
		end
		assert (ones >= 16447 && ones <= 16449)
		else stop_with_error($sformatf("mismatch at time %0t: audio_l ones is %0d, expected 16448",
			$time, ones));
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- rtl/arcade_glue.sv
/*
 * Board glue between the menu controller and the arcade core.
 * Wires ROM loading, reset, controls, video and audio together.
 */
`timescale 1ns/1ps

module arcade_glue (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic ioctl_download,
	input  logic ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0] ioctl_dout,
	input  logic [arcade_pkg::rom_addr_w-1:0] rom_addr,
	input  logic [31:0] status,
	input  logic [1:0] buttons,
	input  logic key_strobe,
	input  logic key_pressed,
	input  logic [7:0] key_code,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic [1:0] r,
	input  logic [2:0] g,
	input  logic [2:0] b,
	input  logic hs,
	input  logic vs,
	input  logic blankn,
	input  logic [arcade_pkg::audio_w-1:0] audio,
	output logic [7:0] rom_data,
	output logic game_reset,
	output logic up,
	output logic down,
	output logic left,
	output logic right,
	output logic fire,
	output logic bomb,
	output logic coin,
	output logic one_player,
	output logic two_players,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic audio_l,
	output logic audio_r
);

	import arcade_pkg::*;

	logic reset_request;
	logic kb_up, kb_down, kb_left, kb_right, kb_fire, kb_bomb;
	logic dac_bit;

	// menu reset, second menu reset and board button
	assign reset_request = status[status_reset] | status[status_menu_reset] | buttons[1];

	rom_loader u_rom_loader (
		.clk_sys, .arst_n, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.rom_addr, .reset_request, .rom_data, .game_reset
	);

	key_decoder u_key_decoder (
		.clk_sys, .arst_n, .key_strobe, .key_pressed, .key_code,
		.kb_up, .kb_down, .kb_left, .kb_right, .kb_fire, .kb_bomb,
		.coin, .one_player, .two_players
	);

	control_mapper u_control_mapper (
		.clk_sys, .arst_n, .rotate(status[status_rotate]),
		.kb_up, .kb_down, .kb_left, .kb_right, .kb_fire, .kb_bomb,
		.joystick_0, .joystick_1, .up, .down, .left, .right, .fire, .bomb
	);

	video_out u_video_out (
		.clk_sys, .arst_n, .r, .g, .b, .hs, .vs, .blankn,
		.vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs
	);

	// byte repeated to fill the 16-bit DAC
	audio_dac #(.dac_w(16)) u_audio_dac (
		.clk_sys, .arst_n, .sample({audio, audio}), .dac_bit
	);

	assign audio_l = dac_bit;
	assign audio_r = dac_bit;

endmodule

//--- rtl/video_out.sv
/*
 * Blanks and widens the core's 2-3-3 colour to 6 bits per channel.
 * Syncs pass through the same register stage as the colours.
 */
`timescale 1ns/1ps

module video_out (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic [1:0] r,
	input  logic [2:0] g,
	input  logic [2:0] b,
	input  logic hs,
	input  logic vs,
	input  logic blankn,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic vga_hs,
	output logic vga_vs
);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			if (blankn) begin
				vga_r <= {r, r, r};	// repeat so full scale stays full scale
				vga_g <= {g, g};
				vga_b <= {b, b};
			end else begin
				vga_r <= '0;
				vga_g <= '0;
				vga_b <= '0;
			end
			vga_hs <= hs;
			vga_vs <= vs;
		end
	end

endmodule

//--- rtl/audio_dac.sv
/*
 * First-order sigma-delta DAC with a one-bit output for an RC filter.
 * Density of ones on dac_bit is sample / 2**dac_w.
 */
`timescale 1ns/1ps

module audio_dac #(
	parameter int dac_w = 16
) (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic [dac_w-1:0] sample,
	output logic dac_bit
);

	logic [dac_w:0] acc;	// top bit is the carry

	// carry is dropped before the next add, the residue stays
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[dac_w-1:0]} + {1'b0, sample};
		end
	end

	assign dac_bit = acc[dac_w];

endmodule

//--- rtl/control_mapper.sv
/*
 * Merges keyboard and both joysticks into the core's control inputs.
 * rotate low selects the quarter-turn layout for a rotated monitor.
 */
`timescale 1ns/1ps

module control_mapper (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic rotate,
	input  logic kb_up,
	input  logic kb_down,
	input  logic kb_left,
	input  logic kb_right,
	input  logic kb_fire,
	input  logic kb_bomb,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	output logic up,
	output logic down,
	output logic left,
	output logic right,
	output logic fire,
	output logic bomb
);

	import arcade_pkg::*;

	logic raw_up, raw_down, raw_left, raw_right;

	assign raw_up = kb_up | joystick_0[joy_up] | joystick_1[joy_up];
	assign raw_down = kb_down | joystick_0[joy_down] | joystick_1[joy_down];
	assign raw_left = kb_left | joystick_0[joy_left] | joystick_1[joy_left];
	assign raw_right = kb_right | joystick_0[joy_right] | joystick_1[joy_right];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			{up, down, left, right, fire, bomb} <= '0;
		end else begin
			up <= rotate ? raw_up : raw_left;
			down <= rotate ? raw_down : raw_right;
			left <= rotate ? raw_left : raw_down;
			right <= rotate ? raw_right : raw_up;
			fire <= kb_fire | joystick_0[joy_fire] | joystick_1[joy_fire];	// never rotated
			bomb <= kb_bomb | joystick_0[joy_bomb] | joystick_1[joy_bomb];
		end
	end

endmodule

//--- rtl/key_decoder.sv
/*
 * Turns PS/2 make and break events into held button levels.
 * Each strobe updates at most one button; unknown codes are ignored.
 */
`timescale 1ns/1ps

module key_decoder (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic key_strobe,
	input  logic key_pressed,
	input  logic [7:0] key_code,
	output logic kb_up,
	output logic kb_down,
	output logic kb_left,
	output logic kb_right,
	output logic kb_fire,
	output logic kb_bomb,
	output logic coin,
	output logic one_player,
	output logic two_players
);

	import arcade_pkg::*;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			kb_up <= 1'b0;
			kb_down <= 1'b0;
			kb_left <= 1'b0;
			kb_right <= 1'b0;
			kb_fire <= 1'b0;
			kb_bomb <= 1'b0;
			coin <= 1'b0;
			one_player <= 1'b0;
			two_players <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				key_up: kb_up <= key_pressed;
				key_down: kb_down <= key_pressed;
				key_left: kb_left <= key_pressed;
				key_right: kb_right <= key_pressed;
				key_fire: kb_fire <= key_pressed;
				key_bomb: kb_bomb <= key_pressed;
				key_coin: coin <= key_pressed;
				key_one_player: one_player <= key_pressed;
				key_two_players: two_players <= key_pressed;
				default: ;	// not a game key
			endcase
		end
	end

endmodule

//--- rtl/rom_loader.sv
/*
 * On-chip game ROM, written by the download stream and read by the core.
 * Also holds the core in reset until the first download has finished.
 */
`timescale 1ns/1ps

module rom_loader (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic ioctl_download,
	input  logic ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0] ioctl_dout,
	input  logic [arcade_pkg::rom_addr_w-1:0] rom_addr,
	input  logic reset_request,
	output logic [7:0] rom_data,
	output logic game_reset
);

	import arcade_pkg::*;

	logic [7:0] rom_mem [rom_depth];
	logic dl_q;	// download level, registered
	logic dl_d;	// delayed copy
	logic dl_fall;
	logic loaded;

	// write port during download, read port otherwise
	always_ff @(posedge clk_sys) begin
		if (ioctl_download && ioctl_wr) begin
			rom_mem[ioctl_addr[rom_addr_w-1:0]] <= ioctl_dout;
		end
		if (!ioctl_download) begin
			rom_data <= rom_mem[rom_addr];
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_q <= 1'b0;
			dl_d <= 1'b0;
			dl_fall <= 1'b0;
		end else begin
			dl_q <= ioctl_download;
			dl_d <= dl_q;
			dl_fall <= dl_d & ~dl_q;	// one pulse per download end
		end
	end

	// sticky, only arst_n clears it
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			loaded <= 1'b0;
		end else if (dl_fall) begin
			loaded <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_reset <= 1'b1;
		end else begin
			game_reset <= reset_request | ~loaded;
		end
	end

endmodule

//--- rtl/arcade_pkg.sv
/*
 * Sizes, key codes and bit positions shared by the arcade glue blocks.
 * Modules import this package inside their body where they need it.
 */
package arcade_pkg;

	// game rom store
	localparam int rom_addr_w = 15;
	localparam int rom_depth = 32768;

	// core audio sample width
	localparam int audio_w = 8;

	// menu status word
	localparam int status_reset = 0;
	localparam int status_rotate = 2;
	localparam int status_menu_reset = 6;

	// joystick bits as delivered by the menu controller
	localparam int joy_right = 0;
	localparam int joy_left = 1;
	localparam int joy_down = 2;
	localparam int joy_up = 3;
	localparam int joy_fire = 4;
	localparam int joy_bomb = 5;

	/* PS/2 set 2 scan codes, without the extended prefix.
	   The arrow keys share their codes with the keypad digits. */
	localparam logic [7:0] key_up = 8'h75;
	localparam logic [7:0] key_down = 8'h72;
	localparam logic [7:0] key_left = 8'h6B;
	localparam logic [7:0] key_right = 8'h74;
	localparam logic [7:0] key_coin = 8'h76;	// esc
	localparam logic [7:0] key_one_player = 8'h05;	// f1
	localparam logic [7:0] key_two_players = 8'h06;	// f2
	localparam logic [7:0] key_fire = 8'h29;	// space
	localparam logic [7:0] key_bomb = 8'h11;	// alt

endpackage
